/* verilog/gmii_rx_pkg.sv */
// GMII receive path package with shared byte types, frame constants and FSM states

package gmii_rx_pkg;

    // One GMII data byte
    typedef logic [7:0] byte_t;

    // Byte count within a frame, room for 1514 and some margin
    typedef logic [10:0] frame_len_t;

    ///////////////////////////////////////////////////////////////////////
    // Frame delimiters
    ///////////////////////////////////////////////////////////////////////

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;

    // Trailing CRC bytes, also the depth of the FCS delay line
    localparam int FCS_BYTES = 4;

    ///////////////////////////////////////////////////////////////////////
    // State machines
    ///////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        HUNT,
        PREAMBLE,
        PASS,
        DROP
    } sfd_state_t;

    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        PAD,
        DISCARD
    } len_state_t;

endpackage

/* verilog/crc_stripper.sv */
// CRC stripper that registers the GMII input and drops the four FCS bytes of each frame
`timescale 1ns/1ps

module crc_stripper
    import gmii_rx_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rx_dv,
    input  logic  rx_er,
    input  byte_t rxd,
    output logic  dv,
    output logic  er,
    output byte_t data
);

    localparam int CNT_W = $clog2(FCS_BYTES + 1);

    logic                 dv_r;
    logic                 dv_d;
    logic                 er_r;
    byte_t                data_r;
    logic                 rise;
    logic                 fall;
    logic [CNT_W-1:0]     fill_cnt;
    logic                 full;
    byte_t                line_data [FCS_BYTES];
    logic [FCS_BYTES-1:0] line_er;

    // Input register and previous dv for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dv_r <= 1'b0;
            dv_d <= 1'b0;
        end else begin
            dv_r <= rx_dv;
            dv_d <= dv_r;
        end
    end

    always_ff @(posedge clk) begin
        er_r   <= rx_er;
        data_r <= rxd;
    end

    assign rise = dv_r & ~dv_d;
    assign fall = ~dv_r & dv_d;

    ///////////////////////////////////////////////////////////////////////
    // FCS delay line
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (dv_r) begin
            line_data[0] <= data_r;
            line_er[0]   <= er_r;
            for (int i = 1; i < FCS_BYTES; i++) begin
                line_data[i] <= line_data[i-1];
                line_er[i]   <= line_er[i-1];
            end
        end
    end

    // Line is empty again once the frame ends, so the held FCS bytes never leave
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else if (fall) begin
            fill_cnt <= '0;
        end else if (rise) begin
            fill_cnt <= CNT_W'(1);
        end else if (dv_r && !full) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    assign full = (fill_cnt == CNT_W'(FCS_BYTES));

    // Forward only while the frame is still arriving
    assign dv   = dv_r & full;
    assign er   = dv & line_er[FCS_BYTES-1];
    assign data = dv ? line_data[FCS_BYTES-1] : '0;

endmodule

/* verilog/sfd_detector.sv */
// SFD detector that checks the preamble, drops malformed frames and strips preamble and SFD
`timescale 1ns/1ps

module sfd_detector
    import gmii_rx_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_dv,
    input  logic  in_er,
    input  byte_t in_data,
    output logic  dv,
    output logic  er,
    output byte_t data
);

    sfd_state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= HUNT;
            dv    <= 1'b0;
            er    <= 1'b0;
            data  <= '0;
        end else begin
            // Nothing leaves unless the frame is in PASS
            dv   <= 1'b0;
            er   <= 1'b0;
            data <= '0;

            case (state)
                HUNT: begin
                    if (in_dv) begin
                        if (in_data == PREAMBLE_BYTE) begin
                            state <= PREAMBLE;
                        end else begin
                            state <= DROP;
                        end
                    end
                end

                PREAMBLE: begin
                    // Frame ended before the SFD, nothing to throw away
                    if (!in_dv) begin
                        state <= HUNT;
                    end else if (in_data == SFD_BYTE) begin
                        state <= PASS;
                    end else if (in_data != PREAMBLE_BYTE) begin
                        state <= DROP;
                    end
                end

                PASS: begin
                    if (in_dv) begin
                        dv   <= 1'b1;
                        er   <= in_er;
                        data <= in_data;
                    end else begin
                        state <= HUNT;
                    end
                end

                DROP: begin
                    if (!in_dv) begin
                        state <= HUNT;
                    end
                end

                default: begin
                    state <= HUNT;
                end
            endcase
        end
    end

endmodule

/* verilog/length_limiter.sv */
// Length limiter that pads short frames with zeros and truncates long ones
`timescale 1ns/1ps

module length_limiter
    import gmii_rx_pkg::*;
#(
    parameter int MIN_FRAME = 60,
    parameter int MAX_FRAME = 1514
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_dv,
    input  logic  in_er,
    input  byte_t in_data,
    output logic  out_dv,
    output logic  out_er,
    output byte_t out_data
);

    localparam frame_len_t MIN_LEN = frame_len_t'(MIN_FRAME);
    localparam frame_len_t MAX_LEN = frame_len_t'(MAX_FRAME);

    len_state_t state;
    frame_len_t count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            count    <= '0;
            out_dv   <= 1'b0;
            out_er   <= 1'b0;
            out_data <= '0;
        end else begin
            out_dv   <= 1'b0;
            out_er   <= 1'b0;
            out_data <= '0;

            case (state)
                IDLE: begin
                    count <= '0;
                    if (in_dv) begin
                        out_dv   <= 1'b1;
                        out_er   <= in_er;
                        out_data <= in_data;
                        count    <= frame_len_t'(1);
                        state    <= FORWARD;
                    end
                end

                FORWARD: begin
                    if (in_dv) begin
                        if (count == MAX_LEN) begin
                            // Truncate, rest of frame is swallowed
                            state <= DISCARD;
                        end else begin
                            out_dv   <= 1'b1;
                            out_er   <= in_er;
                            out_data <= in_data;
                            count    <= count + 1'b1;
                        end
                    end else if (count < MIN_LEN) begin
                        // First pad byte right behind the last data byte
                        out_dv <= 1'b1;
                        count  <= count + 1'b1;
                        state  <= PAD;
                    end else begin
                        state <= IDLE;
                    end
                end

                PAD: begin
                    if (count == MIN_LEN) begin
                        state <= IDLE;
                    end else begin
                        out_dv <= 1'b1;
                        count  <= count + 1'b1;
                    end
                end

                DISCARD: begin
                    if (!in_dv) begin
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/gmii_rx_ctrl.sv */
// GMII receive conditioner top chaining FCS removal, preamble check and length limiting
`timescale 1ns/1ps

module gmii_rx_ctrl
    import gmii_rx_pkg::*;
#(
    parameter int MIN_FRAME = 60,
    parameter int MAX_FRAME = 1514
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rx_dv,
    input  logic  rx_er,
    input  byte_t rxd,
    output logic  out_dv,
    output logic  out_er,
    output byte_t out_data
);

    logic  crc_dv;
    logic  crc_er;
    byte_t crc_data;
    logic  sfd_dv;
    logic  sfd_er;
    byte_t sfd_data;

    ///////////////////////////////////////////////////////////////////////
    // Receive pipeline, seven cycles from rxd to out_data
    ///////////////////////////////////////////////////////////////////////

    crc_stripper crc_stripper_i (
        .clk   (clk),
        .rst_n (rst_n),
        .rx_dv (rx_dv),
        .rx_er (rx_er),
        .rxd   (rxd),
        .dv    (crc_dv),
        .er    (crc_er),
        .data  (crc_data)
    );

    sfd_detector sfd_detector_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_dv   (crc_dv),
        .in_er   (crc_er),
        .in_data (crc_data),
        .dv      (sfd_dv),
        .er      (sfd_er),
        .data    (sfd_data)
    );

    length_limiter #(
        .MIN_FRAME (MIN_FRAME),
        .MAX_FRAME (MAX_FRAME)
    ) length_limiter_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_dv    (sfd_dv),
        .in_er    (sfd_er),
        .in_data  (sfd_data),
        .out_dv   (out_dv),
        .out_er   (out_er),
        .out_data (out_data)
    );

endmodule

/* tests/clock_gen.sv */
// Testbench clock and reset source with a 40 ns clock and a 16-cycle reset
`timescale 1ns/1ps

module clock_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* tests/gmii_rx_ctrl_checker.sv */
// Output stream assertions for the GMII receive conditioner, bound to its top level
`timescale 1ns/1ps

module gmii_rx_ctrl_checker
    import gmii_rx_pkg::*;
#(
    parameter int MAX_FRAME = 1514
) (
    input logic  clk,
    input logic  rst_n,
    input logic  out_dv,
    input logic  out_er,
    input byte_t out_data
);

    int assert_errors = 0;
    int run_len;

    // Cycles of out_dv seen so far in the current run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_len <= 0;
        end else if (out_dv) begin
            run_len <= run_len + 1;
        end else begin
            run_len <= 0;
        end
    end

    er_needs_dv: assert property (@(posedge clk) disable iff (!rst_n) out_er |-> out_dv)
        else begin
            $error("out_er high while out_dv is low");
            assert_errors++;
        end

    idle_is_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_dv |-> (out_data == '0))
        else begin
            $error("out_data not zero between frames");
            assert_errors++;
        end

    run_limit: assert property (@(posedge clk) disable iff (!rst_n)
        out_dv |-> (run_len < MAX_FRAME))
        else begin
            $error("out_dv high longer than the maximum frame");
            assert_errors++;
        end

endmodule

bind gmii_rx_ctrl gmii_rx_ctrl_checker #(
    .MAX_FRAME (MAX_FRAME)
) checker_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .out_dv   (out_dv),
    .out_er   (out_er),
    .out_data (out_data)
);

/* tests/gmii_rx_ctrl_tb.sv */
// Testbench for the GMII receive conditioner with a reference model and frame compare
`timescale 1ns/1ps

module gmii_rx_ctrl_tb
    import gmii_rx_pkg::*;
();

    localparam int MIN_FRAME = 60;
    localparam int MAX_FRAME = 1514;
    localparam int IDLE_GAP  = MIN_FRAME + 12;
    localparam int TIMEOUT   = 2000;

    logic       clk;
    logic       rst_n;
    logic       rx_dv;
    logic       rx_er;
    byte_t      rxd;
    logic       out_dv;
    logic       out_er;
    byte_t      out_data;

    integer     seed = 32'hd9e2;
    string      test_name;
    int         test_errors;
    int         pass_count = 0;
    int         fail_count = 0;
    int         frames_seen = 0;
    byte_t      payload [$];
    logic       err_mark [$];
    // Entries are {er, data}
    logic [8:0] expect_q [$];
    logic [8:0] got_q [$];

    clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    gmii_rx_ctrl dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_dv    (rx_dv),
        .rx_er    (rx_er),
        .rxd      (rxd),
        .out_dv   (out_dv),
        .out_er   (out_er),
        .out_data (out_data)
    );

    // Payload cut at the maximum, zero padded to the minimum, empty when dropped
    function automatic void model_frame(input bit malformed);
        expect_q.delete();
        if (!malformed) begin
            for (int i = 0; i < payload.size() && i < MAX_FRAME; i++) begin
                expect_q.push_back({err_mark[i], payload[i]});
            end
            while (expect_q.size() < MIN_FRAME) begin
                expect_q.push_back(9'h000);
            end
        end
    endfunction

    task automatic check_frame();
        int n;
        n = (got_q.size() < expect_q.size()) ? got_q.size() : expect_q.size();
        if (got_q.size() != expect_q.size()) begin
            $display("error %s: length expected %0d actual %0d",
                     test_name, expect_q.size(), got_q.size());
            test_errors++;
        end
        for (int i = 0; i < n; i++) begin
            if (got_q[i] !== expect_q[i]) begin
                $display("error %s: byte %0d expected %h actual %h",
                         test_name, i, expect_q[i], got_q[i]);
                test_errors++;
                break;
            end
        end
    endtask

    // Collect each out_dv run and compare once it ends
    always @(posedge clk) begin
        if (out_dv) begin
            got_q.push_back({out_er, out_data});
        end else if (got_q.size() > 0) begin
            check_frame();
            got_q.delete();
            frames_seen++;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Stimulus
    ///////////////////////////////////////////////////////////////////////

    task automatic make_payload(input int len);
        payload.delete();
        err_mark.delete();
        for (int i = 0; i < len; i++) begin
            payload.push_back(byte_t'($random(seed)));
            err_mark.push_back(1'b0);
        end
    endtask

    // Seven preamble bytes, SFD, payload, four FCS bytes, then idle gap
    task automatic send_frame(input bit bad_preamble);
        int len;
        len = payload.size();
        for (int i = 0; i < len + 12; i++) begin
            @(posedge clk);
            rx_dv <= 1'b1;
            rx_er <= 1'b0;
            rxd   <= PREAMBLE_BYTE;
            if (i < 7 && bad_preamble && i == 3) begin
                rxd <= 8'h12;
            end else if (i == 7) begin
                rxd <= SFD_BYTE;
            end else if (i >= 8 && i < len + 8) begin
                rxd   <= payload[i-8];
                rx_er <= err_mark[i-8];
            end else if (i >= len + 8) begin
                rxd <= byte_t'($random(seed));
            end
        end
        @(posedge clk);
        rx_dv <= 1'b0;
        rx_er <= 1'b0;
        rxd   <= '0;
        repeat (IDLE_GAP) @(posedge clk);
    endtask

    task automatic run_test(input string name, input bit malformed);
        int start;
        int cycles;
        test_name   = name;
        test_errors = 0;
        model_frame(malformed);
        start = frames_seen;
        send_frame(malformed);
        cycles = 0;
        while (frames_seen == start && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!malformed && frames_seen == start) begin
            $display("%s: no output frame within %0d cycles", name, TIMEOUT);
            test_errors++;
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("pass %s", name);
        end else begin
            fail_count++;
            $display("fail %s", name);
        end
    endtask

    initial begin
        int cycles;
        rx_dv  = 1'b0;
        rx_er  = 1'b0;
        rxd    = '0;
        cycles = 0;
        while (!rst_n && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (!rst_n) begin
            $display("reset was never released");
            fail_count++;
        end
        repeat (4) @(posedge clk);

        make_payload(100);
        run_test("basic_100", 1'b0);
        make_payload(20);
        run_test("short_pad", 1'b0);
        make_payload(1600);
        run_test("long_truncate", 1'b0);
        make_payload(64);
        run_test("after_long", 1'b0);
        make_payload(50);
        run_test("bad_preamble", 1'b1);
        make_payload(100);
        run_test("after_bad", 1'b0);
        make_payload(80);
        err_mark[17] = 1'b1;
        err_mark[50] = 1'b1;
        run_test("rx_error", 1'b0);
        for (int k = 0; k < 20; k++) begin
            make_payload(1 + int'($unsigned($random(seed)) % 1600));
            run_test($sformatf("random_%0d", k), 1'b0);
        end

        $display("tests passed %0d failed %0d, assertion failures %0d",
                 pass_count, fail_count, dut_i.checker_i.assert_errors);
        if (fail_count == 0 && dut_i.checker_i.assert_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* gmii_rx_ctrl.f */
verilog/gmii_rx_pkg.sv
verilog/crc_stripper.sv
verilog/sfd_detector.sv
verilog/length_limiter.sv
verilog/gmii_rx_ctrl.sv
tests/clock_gen.sv
tests/gmii_rx_ctrl_checker.sv
tests/gmii_rx_ctrl_tb.sv

/* Makefile */
SIM      = verilator
TOP      = gmii_rx_ctrl_tb
FILELIST = gmii_rx_ctrl.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
RUN_ARGS = +verilator+error+limit+100
PASS_MSG = PASS: all tests

BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
